/* Makefile */
# Verilator build and run for the ooo core
# make        build and run the testbench, fail unless the log shows a pass
# make lint   lint the RTL top level
# make clean  remove build output and log

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
LINT_TOP  ?= ooo_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/completion_buffer.sv */
// completion buffer
// circular reorder buffer indexed by tag
// lanes write results out of order, the head retires in program
// order into the register file, the commit port and the scoreboard

`default_nettype none

module completion_buffer
  import ooo_config_pkg::*;
  import ooo_types_pkg::*;
#(
  parameter int NUM_LANES = 3,
  parameter int CB_DEPTH  = 4
) (
  input  logic                   CLK,
  input  logic                   nRST,
  // allocation from dispatch
  input  logic                   alloc,
  output logic                   cb_full,
  output logic [MAX_TAG_W-1:0]   tail_tag,
  // lane results
  input  logic [NUM_LANES-1:0]   result_valid,
  input  lane_result_t           result [NUM_LANES],
  // retirement
  output logic                   retire_valid,
  output logic [REG_ADDR_W-1:0]  retire_rd,
  output logic                   rf_we,
  output commit_rec_t            rf_wr,
  output logic                   commit_valid,
  output commit_rec_t            commit
);

  localparam int IDX_W = (CB_DEPTH > 1) ? $clog2(CB_DEPTH) : 1;

  logic [IDX_W-1:0]       head_q;
  logic [IDX_W-1:0]       tail_q;
  logic [IDX_W:0]         count_q;
  logic [CB_DEPTH-1:0]    done_q;
  logic [REG_ADDR_W-1:0]  rd_q  [CB_DEPTH];
  logic [XLEN-1:0]        val_q [CB_DEPTH];
  logic                   retire;

  // pointer step with wrap at CB_DEPTH
  function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] p);
    next_ptr = (p == IDX_W'(CB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign cb_full  = (count_q == (IDX_W+1)'(CB_DEPTH));
  assign tail_tag = MAX_TAG_W'(tail_q);

  // done head implies a live entry
  assign retire       = done_q[head_q];
  assign retire_valid = retire;
  assign retire_rd    = rd_q[head_q];
  assign rf_we        = retire;
  assign rf_wr        = '{rd: rd_q[head_q], value: val_q[head_q]};
  assign commit_valid = retire;
  assign commit       = rf_wr;

  // pointers, occupancy and done flags
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (alloc) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= next_ptr(tail_q);
      end
      if (retire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= next_ptr(head_q);
      end
      case ({alloc, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // every result has its own slot, take all at once
      for (int i = 0; i < NUM_LANES; i++) begin
        if (result_valid[i]) begin
          done_q[result[i].tag[IDX_W-1:0]] <= 1'b1;
        end
      end
    end
  end

  // entry payload
  always_ff @(posedge CLK) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (result_valid[i]) begin
        rd_q[result[i].tag[IDX_W-1:0]]  <= result[i].rd;
        val_q[result[i].tag[IDX_W-1:0]] <= result[i].value;
      end
    end
  end

endmodule

`default_nettype wire

/* source/dispatch_unit.sv */
// dispatch unit
// wishbone classic slave, instruction decode and scoreboard
// an instruction write is acked only once a lane is idle, the
// completion buffer has room and no operand or rd write is pending
// register reads go through the debug port of the register file

`default_nettype none

module dispatch_unit
  import ooo_config_pkg::*;
  import ooo_types_pkg::*;
#(
  parameter int NUM_LANES = 3
) (
  input  logic                   CLK,
  input  logic                   nRST,
  // wishbone slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [REG_ADDR_W:0]    wb_adr,
  input  logic [XLEN-1:0]        wb_dat_w,
  output logic [XLEN-1:0]        wb_dat_r,
  output logic                   wb_ack,
  // lanes
  input  logic [NUM_LANES-1:0]   lane_idle,
  output logic [NUM_LANES-1:0]   issue_valid,
  output issue_t                 issue,
  // completion buffer
  input  logic                   cb_full,
  input  logic [MAX_TAG_W-1:0]   tail_tag,
  output logic                   alloc,
  input  logic                   retire_valid,
  input  logic [REG_ADDR_W-1:0]  retire_rd,
  // register file
  output logic [REG_ADDR_W-1:0]  rs1_addr,
  output logic [REG_ADDR_W-1:0]  rs2_addr,
  input  logic [XLEN-1:0]        rs1_value,
  input  logic [XLEN-1:0]        rs2_value,
  output logic [REG_ADDR_W-1:0]  dbg_addr,
  input  logic [XLEN-1:0]        dbg_value
);

  instr_t                 instr;
  logic                   req;
  logic                   is_issue;
  logic                   hazard;
  logic                   any_idle;
  logic [NUM_LANES-1:0]   grant;
  logic                   accept;
  // outstanding writes per register
  logic [MAX_TAG_W:0]     pending_q [REG_COUNT];

  // decode straight off the write data
  assign instr    = instr_t'(wb_dat_w);
  assign rs1_addr = instr.rs1;
  assign rs2_addr = instr.rs2;
  assign dbg_addr = wb_adr[REG_ADDR_W-1:0];

  // new request, not the one being acked
  assign req      = wb_cyc && wb_stb && !wb_ack;
  assign is_issue = wb_we && (wb_adr == (REG_ADDR_W+1)'(ISSUE_ADR));

  // r0 is never pending
  assign hazard = (pending_q[instr.rs1] != '0) ||
                  (pending_q[instr.rs2] != '0) ||
                  (pending_q[instr.rd]  != '0);

  // lowest-numbered idle lane wins
  always_comb begin
    grant    = '0;
    any_idle = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_idle[i] && !any_idle) begin
        grant[i] = 1'b1;
        any_idle = 1'b1;
      end
    end
  end

  assign accept = req && is_issue && any_idle && !cb_full && !hazard;
  // tail tag taken in the accept cycle
  assign alloc  = accept;

  // ack and issue go out together
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_ack      <= 1'b0;
      issue_valid <= '0;
    end else begin
      wb_ack      <= req && (!is_issue || accept);
      issue_valid <= accept ? grant : '0;
    end
  end

  // read data and issue payload
  always_ff @(posedge CLK) begin
    if (req && !wb_we) begin
      wb_dat_r <= (wb_adr < (REG_ADDR_W+1)'(REG_COUNT)) ? dbg_value : '0;
    end
    if (accept) begin
      issue.tag <= tail_tag;
      issue.op  <= instr.op;
      issue.rd  <= instr.rd;
      issue.a   <= rs1_value;
      issue.b   <= rs2_value;
      issue.imm <= instr.imm;
    end
  end

  // scoreboard, set on accept and cleared on retire
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < REG_COUNT; r++) begin
        pending_q[r] <= '0;
      end
    end else begin
      for (int r = 1; r < REG_COUNT; r++) begin
        if (accept && instr.rd == REG_ADDR_W'(r)) begin
          if (!(retire_valid && retire_rd == REG_ADDR_W'(r))) begin
            pending_q[r] <= pending_q[r] + 1'b1;
          end
        end else if (retire_valid && retire_rd == REG_ADDR_W'(r)) begin
          pending_q[r] <= pending_q[r] - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/exec_lane.sv */
// execution lane
// single-cycle ALU plus an iterative shift-and-add multiplier
// holds tag and rd while busy and presents one result per issue

`default_nettype none

module exec_lane
  import ooo_config_pkg::*;
  import ooo_types_pkg::*;
#(
  parameter int MUL_CYCLES_P = 32
) (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          issue_valid,
  input  issue_t        issue,
  output logic          lane_idle,
  output logic          result_valid,
  output lane_result_t  result
);

  localparam int CNT_W = $clog2(MUL_CYCLES_P + 1);
  localparam int SH_W  = $clog2(XLEN);

  lane_state_e            state;
  logic [CNT_W-1:0]       cnt_q;
  logic [MAX_TAG_W-1:0]   tag_q;
  logic [REG_ADDR_W-1:0]  rd_q;
  // acc doubles as the result register
  logic [XLEN-1:0]        acc_q;
  logic [XLEN-1:0]        mcand_q;
  logic [XLEN-1:0]        mplier_q;
  logic [XLEN-1:0]        alu_value;
  logic                   start;

  assign start        = (state == IDLE) && issue_valid;
  assign lane_idle    = (state == IDLE);
  assign result_valid = (state == DONE);
  assign result       = '{tag: tag_q, rd: rd_q, value: acc_q};

  // single-cycle ops
  always_comb begin
    case (issue.op)
      OP_ADD:  alu_value = issue.a + issue.b;
      OP_SUB:  alu_value = issue.a - issue.b;
      OP_AND:  alu_value = issue.a & issue.b;
      OP_OR:   alu_value = issue.a | issue.b;
      OP_XOR:  alu_value = issue.a ^ issue.b;
      // shift amount from rs2 low bits
      OP_SLL:  alu_value = issue.a << issue.b[SH_W-1:0];
      OP_SRL:  alu_value = issue.a >> issue.b[SH_W-1:0];
      OP_ADDI: alu_value = issue.a + {{(XLEN-16){issue.imm[15]}}, issue.imm};
      OP_LUI:  alu_value = {issue.imm, {(XLEN-16){1'b0}}};
      default: alu_value = '0;
    endcase
  end

  // lane FSM
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      cnt_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          cnt_q <= '0;
          if (issue_valid) begin
            if (issue.op == OP_MUL) begin
              state <= MUL_BUSY;
            end else begin
              state <= DONE;
            end
          end
        end
        MUL_BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(MUL_CYCLES_P - 1)) begin
            state <= DONE;
          end
        end
        // result shown for one cycle
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // datapath, one multiplier bit per cycle
  always_ff @(posedge CLK) begin
    if (start) begin
      tag_q    <= issue.tag;
      rd_q     <= issue.rd;
      mcand_q  <= issue.a;
      mplier_q <= issue.b;
      // alu gives zero for mul, which seeds the accumulator
      acc_q    <= alu_value;
    end else if (state == MUL_BUSY) begin
      acc_q    <= acc_q + (mplier_q[0] ? mcand_q : '0);
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

endmodule

`default_nettype wire

/* source/ooo_config_pkg.sv */
// ooo core configuration
// datapath width, register file size and completion buffer limits
// shared by every block of the core and by the testbench

`default_nettype none

package ooo_config_pkg;

  // data path width
  localparam int XLEN = 32;

  // architectural registers, r0 reads zero
  localparam int REG_COUNT  = 16;
  localparam int REG_ADDR_W = 4;

  // completion tag width, caps buffer depth at 8
  localparam int MAX_TAG_W = 3;

  // shift-and-add iterations per multiply
  localparam int MUL_CYCLES = 32;

  // wishbone word address that issues an instruction
  localparam int ISSUE_ADR = 16;

endpackage

`default_nettype wire

/* source/ooo_core.sv */
// ooo integer core top level
// wishbone slave into dispatch, NUM_LANES execution lanes,
// in-order retirement through the completion buffer
// and a commit port reporting every retired result

`default_nettype none

module ooo_core
  import ooo_config_pkg::*;
  import ooo_types_pkg::*;
#(
  parameter int NUM_LANES = 3,
  parameter int CB_DEPTH  = 4
) (
  input  logic                 CLK,
  input  logic                 nRST,
  // wishbone classic slave
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [REG_ADDR_W:0]  wb_adr,
  input  logic [XLEN-1:0]      wb_dat_w,
  output logic [XLEN-1:0]      wb_dat_r,
  output logic                 wb_ack,
  // retirement report
  output logic                 commit_valid,
  output commit_rec_t          commit
);

  // dispatch and lanes
  logic [NUM_LANES-1:0]   lane_idle;
  logic [NUM_LANES-1:0]   issue_valid;
  issue_t                 issue;
  logic [NUM_LANES-1:0]   result_valid;
  lane_result_t           lane_result [NUM_LANES];
  // completion buffer
  logic                   alloc;
  logic                   cb_full;
  logic [MAX_TAG_W-1:0]   tail_tag;
  logic                   retire_valid;
  logic [REG_ADDR_W-1:0]  retire_rd;
  logic                   rf_we;
  commit_rec_t            rf_wr;
  // register file ports
  logic [REG_ADDR_W-1:0]  rs1_addr;
  logic [REG_ADDR_W-1:0]  rs2_addr;
  logic [REG_ADDR_W-1:0]  dbg_addr;
  logic [XLEN-1:0]        rs1_value;
  logic [XLEN-1:0]        rs2_value;
  logic [XLEN-1:0]        dbg_value;

  dispatch_unit #(.NUM_LANES(NUM_LANES)) dispatch_i (.*);

  reg_file reg_file_i (.*);

  completion_buffer #(
    .NUM_LANES(NUM_LANES),
    .CB_DEPTH (CB_DEPTH)
  ) cb_i (
    .result(lane_result),
    .*
  );

  // one lane per slot, all fed by the shared issue record
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    exec_lane #(.MUL_CYCLES_P(MUL_CYCLES)) lane_i (
      .CLK         (CLK),
      .nRST        (nRST),
      .issue_valid (issue_valid[i]),
      .issue       (issue),
      .lane_idle   (lane_idle[i]),
      .result_valid(result_valid[i]),
      .result      (lane_result[i])
    );
  end

endmodule

`default_nettype wire

/* source/ooo_types_pkg.sv */
// ooo core types
// opcodes, lane states and the packed records passed between
// dispatch, the execution lanes and the completion buffer

`default_nettype none

package ooo_types_pkg;
  import ooo_config_pkg::*;

  // micro-instruction opcodes
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    OP_ADDI = 4'h7,
    OP_LUI  = 4'h8,
    OP_MUL  = 4'h9
  } opcode_e;

  // execution lane FSM
  typedef enum logic [1:0] {
    IDLE,
    MUL_BUSY,
    DONE
  } lane_state_e;

  // instruction word, opcode in the top nibble
  typedef struct packed {
    opcode_e                op;
    logic [REG_ADDR_W-1:0]  rd;
    logic [REG_ADDR_W-1:0]  rs1;
    logic [REG_ADDR_W-1:0]  rs2;
    logic [15:0]            imm;
  } instr_t;

  // dispatch to lane
  typedef struct packed {
    logic [MAX_TAG_W-1:0]   tag;
    opcode_e                op;
    logic [REG_ADDR_W-1:0]  rd;
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [15:0]            imm;
  } issue_t;

  // lane to completion buffer
  typedef struct packed {
    logic [MAX_TAG_W-1:0]   tag;
    logic [REG_ADDR_W-1:0]  rd;
    logic [XLEN-1:0]        value;
  } lane_result_t;

  // retired result, also the register file write
  typedef struct packed {
    logic [REG_ADDR_W-1:0]  rd;
    logic [XLEN-1:0]        value;
  } commit_rec_t;

endpackage

`default_nettype wire

/* source/reg_file.sv */
// architectural register file
// two operand read ports, one debug read port, one commit write port
// r0 is hardwired to zero

`default_nettype none

module reg_file
  import ooo_config_pkg::*;
  import ooo_types_pkg::*;
(
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic [REG_ADDR_W-1:0]  rs1_addr,
  input  logic [REG_ADDR_W-1:0]  rs2_addr,
  input  logic [REG_ADDR_W-1:0]  dbg_addr,
  input  logic                   rf_we,
  input  commit_rec_t            rf_wr,
  output logic [XLEN-1:0]        rs1_value,
  output logic [XLEN-1:0]        rs2_value,
  output logic [XLEN-1:0]        dbg_value
);

  // no storage behind r0
  logic [XLEN-1:0] regs [1:REG_COUNT-1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 1; r < REG_COUNT; r++) begin
        regs[r] <= '0;
      end
    end else if (rf_we && rf_wr.rd != '0) begin
      regs[rf_wr.rd] <= rf_wr.value;
    end
  end

  // async reads
  assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];
  assign dbg_value = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

/* tb/ooo_core_tb.sv */
// ooo core testbench
// wishbone master driven from the test file, commit monitor and
// compare tasks for commits and register read-back
// one line per test, then the counts and the overall result

`default_nettype none

module ooo_core_tb
  import ooo_config_pkg::*;
  import ooo_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    NUM_LANES = 3;
  localparam int    CB_DEPTH  = 4;
  localparam int    TIMEOUT   = 200;
  localparam string TEST_FILE = "tb/ooo_tests.txt";

  logic                 CLK;
  logic                 nRST;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [REG_ADDR_W:0]  wb_adr;
  logic [XLEN-1:0]      wb_dat_w;
  logic [XLEN-1:0]      wb_dat_r;
  logic                 wb_ack;
  logic                 commit_valid;
  commit_rec_t          commit;

  // current test records
  logic [XLEN-1:0]        instr_q [$];
  commit_rec_t            exp_commit_q [$];
  logic [REG_ADDR_W-1:0]  exp_reg_q [$];
  logic [XLEN-1:0]        exp_val_q [$];
  // commits seen on the port
  commit_rec_t            seen_q [$];

  logic [31:0]  lfsr;
  int           tests_run;
  int           tests_ok;
  int           tests_bad;
  logic         aborted;

  ooo_core #(
    .NUM_LANES(NUM_LANES),
    .CB_DEPTH (CB_DEPTH)
  ) ooo_core_i (.*);

  // 100 ns clock
  always #50 CLK = ~CLK;

  // commit monitor, sampled away from the rising edge
  always @(negedge CLK) begin
    if (nRST && commit_valid) begin
      seen_q.push_back(commit);
    end
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // 0 to 3 idle cycles, two lfsr bits
  task automatic idle_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_step(lfsr);
      gap  = (gap << 1) | int'(lfsr[0]);
    end
    repeat (gap) @(posedge CLK);
  endtask

  // one classic wishbone transfer, ok low when no ack came
  task automatic bus_cycle(input logic we, input logic [REG_ADDR_W:0] adr,
                           input logic [XLEN-1:0] wdata,
                           output logic [XLEN-1:0] rdata, output logic ok);
    int waited;
    idle_gap();
    @(posedge CLK);
    #10;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    ok       = 1'b0;
    rdata    = '0;
    while (!ok && waited < TIMEOUT) begin
      @(negedge CLK);
      if (wb_ack) begin
        ok    = 1'b1;
        rdata = wb_dat_r;
      end
      waited++;
    end
    // drop stb after the ack cycle
    @(posedge CLK);
    #10;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // wait until n commits are queued
  task automatic wait_commits(input int n, output logic ok);
    int waited;
    waited = 0;
    while (seen_q.size() < n && waited < TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    ok = (seen_q.size() >= n);
  endtask

  task automatic check_commit(input string name, input int idx, input commit_rec_t exp,
                              input commit_rec_t act, inout int errs);
    if (act !== exp) begin
      $display("Error %s: commit %0d expected rd %0d value %h, actual rd %0d value %h",
               name, idx, exp.rd, exp.value, act.rd, act.value);
      errs++;
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] r,
                           input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act,
                           inout int errs);
    if (act !== exp) begin
      $display("Error %s: r%0d expected %h, actual %h", name, r, exp, act);
      errs++;
    end
  endtask

  // issue, wait for the commits, compare, then read back registers
  task automatic run_test(input string name);
    int               errs;
    logic             ok;
    logic [XLEN-1:0]  rdata;
    errs = 0;
    seen_q.delete();
    foreach (instr_q[k]) begin
      if (!aborted) begin
        bus_cycle(1'b1, (REG_ADDR_W+1)'(ISSUE_ADR), instr_q[k], rdata, ok);
        if (!ok) begin
          $display("test %s: instruction %h was not acked within %0d cycles",
                   name, instr_q[k], TIMEOUT);
          aborted = 1'b1;
        end
      end
    end
    if (!aborted) begin
      wait_commits(exp_commit_q.size(), ok);
      if (!ok) begin
        $display("test %s: only %0d of %0d commits arrived within %0d cycles",
                 name, seen_q.size(), exp_commit_q.size(), TIMEOUT);
        aborted = 1'b1;
      end
    end
    if (!aborted) begin
      foreach (exp_commit_q[k]) begin
        check_commit(name, k, exp_commit_q[k], seen_q[k], errs);
      end
    end
    foreach (exp_reg_q[k]) begin
      if (!aborted) begin
        bus_cycle(1'b0, {1'b0, exp_reg_q[k]}, '0, rdata, ok);
        if (!ok) begin
          $display("test %s: read of r%0d was not acked within %0d cycles",
                   name, exp_reg_q[k], TIMEOUT);
          aborted = 1'b1;
        end else begin
          check_reg(name, exp_reg_q[k], exp_val_q[k], rdata, errs);
        end
      end
    end
    // stray commits show up by the end of the read-back
    if (!aborted && seen_q.size() != exp_commit_q.size()) begin
      $display("test %s: %0d commits seen where %0d were expected",
               name, seen_q.size(), exp_commit_q.size());
      errs++;
    end
    tests_run++;
    if (errs == 0 && !aborted) begin
      tests_ok++;
      $display("test %-12s ok", name);
    end else begin
      tests_bad++;
      $display("test %-12s failing, %0d mismatches", name, errs);
    end
  endtask

  initial begin
    string            tok;
    string            name;
    string            line;
    int               fd;
    int               code;
    int               need;
    logic [XLEN-1:0]  v1;
    logic [XLEN-1:0]  v2;
    commit_rec_t      rec;
    CLK       = 1'b0;
    nRST      = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    lfsr      = 32'hd7aa43f2;
    tests_run = 0;
    tests_ok  = 0;
    tests_bad = 0;
    aborted   = 1'b0;
    name      = "none";
    // reset for 16 cycles
    repeat (16) @(posedge CLK);
    #10;
    nRST = 1'b1;

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("could not open the test file %s", TEST_FILE);
      aborted = 1'b1;
    end
    while (!aborted && $fscanf(fd, "%s", tok) == 1) begin
      // fields each record still has to supply
      need = 0;
      code = 0;
      if (tok.substr(0, 0) == "#") begin
        // rest of a comment line
        code = $fgets(line, fd);
      end else if (tok == "T") begin
        need = 1;
        code = $fscanf(fd, "%s", name);
        instr_q.delete();
        exp_commit_q.delete();
        exp_reg_q.delete();
        exp_val_q.delete();
      end else if (tok == "I") begin
        need = 1;
        code = $fscanf(fd, "%h", v1);
        instr_q.push_back(v1);
      end else if (tok == "C") begin
        need      = 2;
        code      = $fscanf(fd, "%h %h", v1, v2);
        rec.rd    = v1[REG_ADDR_W-1:0];
        rec.value = v2;
        exp_commit_q.push_back(rec);
      end else if (tok == "R") begin
        need = 2;
        code = $fscanf(fd, "%h %h", v1, v2);
        exp_reg_q.push_back(v1[REG_ADDR_W-1:0]);
        exp_val_q.push_back(v2);
      end else if (tok == "E") begin
        run_test(name);
      end else begin
        $display("unknown record %s in the test file", tok);
        aborted = 1'b1;
      end
      if (code < need) begin
        $display("incomplete %s record in the test file", tok);
        aborted = 1'b1;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("tests run %0d, ok %0d, failing %0d", tests_run, tests_ok, tests_bad);
    if (tests_bad == 0 && tests_run > 0 && !aborted) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/ooo_tests.txt */
# records: T name | I instr | C rd value | E ends a test and runs it | R reg value
# all numbers hex, instr = op[31:28] rd[27:24] rs1[23:20] rs2[19:16] imm[15:0]
T reset
R 0 0 R 1 0 R 2 0 R 3 0 R 4 0 R 5 0 R 6 0 R 7 0
R 8 0 R 9 0 R a 0 R b 0 R c 0 R d 0 R e 0 R f 0
E
# writes to r0 commit but never show in the read-back
T r0_write
I 70000005 C 0 5
I 71000007 C 1 7
I 00110000 C 0 e
R 0 0 R 1 7
E
# every opcode, addi sign extension, lui placement, shift amount from rs2 low bits
T alu
I 81001234 C 1 12340000
I 71105678 C 1 12345678
I 7200ffff C 2 ffffffff
I 73008000 C 3 ffff8000
I 74000004 C 4 4
I 05140000 C 5 1234567c
I 16410000 C 6 edcba98c
I 27130000 C 7 12340000
I 38130000 C 8 ffffd678
I 49120000 C 9 edcba987
I 5a140000 C a 23456780
I 6b240000 C b 0fffffff
I 7c000024 C c 24
I 5d1c0000 C d 23456780
I 6e2c0000 C e 0fffffff
R 1 12345678 R 3 ffff8000 R 6 edcba98c R 8 ffffd678 R d 23456780 R e 0fffffff
E
# later single-cycle ops finish first but commit after the multiply
T mul_order
I 710004d2 C 1 4d2
I 7200fffd C 2 fffffffd
I 93120000 C 3 fffff18a
I 74000007 C 4 7
I 75000009 C 5 9
I 06450000 C 6 10
R 3 fffff18a R 6 10
E
# each instruction reads the previous rd
T dep_chain
I 71000001 C 1 1
I 01110000 C 1 2
I 01110000 C 1 4
I 92110000 C 2 10
I 03210000 C 3 14
R 1 4 R 2 10 R 3 14
E
# more entries than the completion buffer holds behind a multiply
T cb_full
I 71000003 C 1 3
I 72000005 C 2 5
I 93120000 C 3 f
I 74000001 C 4 1 I 75000002 C 5 2 I 76000003 C 6 3
I 77000004 C 7 4 I 78000005 C 8 5
R 3 f R 7 4 R 8 5
E
# more multiplies than lanes
T lanes_full
I 71000002 C 1 2
I 72000003 C 2 3
I 93120000 C 3 6 I 94110000 C 4 4 I 95220000 C 5 9 I 96120000 C 6 6
R 3 6 R 4 4 R 5 9 R 6 6
E

/* verilog.f */
source/ooo_config_pkg.sv
source/ooo_types_pkg.sv
source/dispatch_unit.sv
source/exec_lane.sv
source/completion_buffer.sv
source/reg_file.sv
source/ooo_core.sv
tb/ooo_core_tb.sv
